// File: verilog/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

    // core data bus width
    localparam int xlen = 32;

    // word address widths of the RAMs and the ROM
    localparam int imem_aw = 14;
    localparam int bios_aw = 12;

    // region is the upper address nibble
    typedef enum logic [3:0] {
        reg_dmem = 4'b0001,
        reg_imem = 4'b0010,
        // stores land in both RAMs, loads come from dmem
        reg_both = 4'b0011,
        reg_bios = 4'b0100,
        reg_io   = 4'b1000
    } region_t;

    // load read-back source
    typedef enum logic [1:0] {
        rsel_dmem,
        rsel_bios,
        rsel_io,
        rsel_none
    } rsel_t;

    // io offsets as word addresses, addr[6:2]
    // byte offsets 0x00, 0x04, 0x08, 0x10, 0x14, 0x18
    localparam logic [4:0] io_uart_ctrl = 5'h00;
    localparam logic [4:0] io_uart_rx   = 5'h01;
    localparam logic [4:0] io_uart_tx   = 5'h02;
    localparam logic [4:0] io_cycles    = 5'h04;
    localparam logic [4:0] io_retired   = 5'h05;
    localparam logic [4:0] io_cnt_clear = 5'h06;

endpackage

`default_nettype wire

// File: verilog/bios_rom.sv
`timescale 1ns/1ps
`default_nettype none

module bios_rom (
    input  logic                            clk,
    // fetch side
    input  logic                            a_en,
    input  logic [mem_map_pkg::bios_aw-1:0] a_addr,
    output logic [mem_map_pkg::xlen-1:0]    a_data,
    // load side
    input  logic                            b_en,
    input  logic [mem_map_pkg::bios_aw-1:0] b_addr,
    output logic [mem_map_pkg::xlen-1:0]    b_data
);
    import mem_map_pkg::*;

    // boot image, never written after load
    logic [xlen-1:0] rom [0:(1 << bios_aw) - 1];

    // only the first words come from the hex image
    initial begin
        $readmemh("verilog/bios.hex", rom);
    end

    // port a, holds while fetch is stalled
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_data <= rom[a_addr];
        end
    end

    // port b, data loads from the bios region
    always_ff @(posedge clk) begin
        if (b_en) begin
            b_data <= rom[b_addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/imem_ram.sv
`timescale 1ns/1ps
`default_nettype none

module imem_ram (
    input  logic                            clk,
    // write port, driven from the data side
    input  logic [3:0]                      we,
    input  logic [mem_map_pkg::imem_aw-1:0] waddr,
    input  logic [mem_map_pkg::xlen-1:0]    wdata,
    // read port for instruction fetch
    input  logic                            r_en,
    input  logic [mem_map_pkg::imem_aw-1:0] raddr,
    output logic [mem_map_pkg::xlen-1:0]    rdata
);
    import mem_map_pkg::*;

    // program storage
    logic [xlen-1:0] ram [0:(1 << imem_aw) - 1];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                ram[waddr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // registered fetch read
    // r_en low keeps the last instruction
    always_ff @(posedge clk) begin
        if (r_en) begin
            rdata <= ram[raddr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/dmem_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_ram (
    input  logic                            clk,
    input  logic                            en,
    input  logic [3:0]                      we,
    input  logic [mem_map_pkg::imem_aw-1:0] addr,
    input  logic [mem_map_pkg::xlen-1:0]    wdata,
    output logic [mem_map_pkg::xlen-1:0]    rdata
);
    import mem_map_pkg::*;

    // data storage, same depth as imem
    logic [xlen-1:0] ram [0:(1 << imem_aw) - 1];

    // single port, read returns the old word on a write
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                // per-byte store
                if (we[i]) begin
                    ram[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata <= ram[addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/mem_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mem_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_map_pkg::region_t data_region,
    input  mem_map_pkg::region_t fetch_region,
    input  logic [3:0]           data_we,
    input  logic                 data_re,
    output logic [3:0]           imem_we,
    output logic [3:0]           dmem_we,
    output logic                 io_we,
    output logic                 io_re,
    output logic                 dmem_en,
    output mem_map_pkg::rsel_t   rsel
);
    import mem_map_pkg::*;

    logic  to_dmem;
    logic  to_imem;
    logic  to_io;
    logic  boot_mode;
    rsel_t rsel_next;

    // region hits for the store side
    assign to_dmem   = (data_region == reg_dmem) || (data_region == reg_both);
    assign to_imem   = (data_region == reg_imem) || (data_region == reg_both);
    assign to_io     = (data_region == reg_io);
    // imem is only writable while running from bios
    assign boot_mode = (fetch_region == reg_bios);

    assign dmem_we = to_dmem ? data_we : 4'b0000;
    assign imem_we = (to_imem && boot_mode) ? data_we : 4'b0000;
    assign io_we   = to_io && (|data_we);
    assign io_re   = to_io && data_re;
    // io accesses leave the data RAM idle
    assign dmem_en = !to_io;

    // where the next load comes back from
    always_comb begin
        case (data_region)
            reg_dmem, reg_both: rsel_next = rsel_dmem;
            reg_bios:           rsel_next = rsel_bios;
            reg_io:             rsel_next = rsel_io;
            // imem is write only from this side
            default:            rsel_next = rsel_none;
        endcase
    end

    // one cycle behind, like the memories
    always_ff @(posedge clk) begin
        if (rst) begin
            rsel <= rsel_none;
        end else begin
            rsel <= data_re ? rsel_next : rsel_none;
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_link.sv
`timescale 1ns/1ps
`default_nettype none

module uart_link #(
    parameter int cpu_clock_freq = 50_000_000,
    parameter int baud_rate      = 115_200
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    input  logic       rx_ack,
    input  logic       serial_in,
    output logic       serial_out
);
    localparam int clks_per_bit = cpu_clock_freq / baud_rate;
    localparam int cnt_w = $clog2(clks_per_bit + 1);
    // last cycle of a bit, and of half a bit
    localparam logic [cnt_w-1:0] bit_last  = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {tx_s_idle, tx_s_start, tx_s_data, tx_s_stop} tx_state_t;
    typedef enum logic [1:0] {rx_s_idle, rx_s_start, rx_s_data, rx_s_stop} rx_state_t;

    tx_state_t        tx_state;
    logic [cnt_w-1:0] tx_cnt;
    logic [2:0]       tx_bit;
    logic [7:0]       tx_buf;
    logic             tx_tick;

    rx_state_t        rx_state;
    logic [1:0]       rx_sync;
    logic             rx_line;
    logic [cnt_w-1:0] rx_cnt;
    logic [2:0]       rx_bit;
    logic [7:0]       rx_shift;
    logic             rx_done;

    // transmitter
    assign tx_ready = (tx_state == tx_s_idle);
    assign tx_tick  = (tx_cnt == bit_last);

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_state <= tx_s_idle;
            tx_cnt   <= '0;
            tx_bit   <= '0;
        end else begin
            // baud divider restarts at each bit boundary
            if (tx_state == tx_s_idle || tx_tick) begin
                tx_cnt <= '0;
            end else begin
                tx_cnt <= tx_cnt + 1'b1;
            end
            case (tx_state)
                tx_s_idle: begin
                    tx_bit <= '0;
                    if (tx_valid) begin
                        tx_state <= tx_s_start;
                    end
                end
                tx_s_start: if (tx_tick) tx_state <= tx_s_data;
                tx_s_data: begin
                    if (tx_tick) begin
                        tx_bit <= tx_bit + 1'b1;
                        if (tx_bit == 3'd7) begin
                            tx_state <= tx_s_stop;
                        end
                    end
                end
                tx_s_stop: if (tx_tick) tx_state <= tx_s_idle;
                default: tx_state <= tx_s_idle;
            endcase
        end
    end

    // byte latched at accept
    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready) begin
            tx_buf <= tx_data;
        end
    end

    // line idles high, lsb first
    always_comb begin
        case (tx_state)
            tx_s_start: serial_out = 1'b0;
            tx_s_data:  serial_out = tx_buf[tx_bit];
            default:    serial_out = 1'b1;
        endcase
    end

    // receiver, two flop synchroniser
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], serial_in};
        end
    end
    assign rx_line = rx_sync[1];

    // stop bit middle, byte only kept on a good stop
    assign rx_done = (rx_state == rx_s_stop) && (rx_cnt == bit_last) && rx_line;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_state <= rx_s_idle;
            rx_cnt   <= '0;
            rx_bit   <= '0;
        end else begin
            case (rx_state)
                rx_s_idle: begin
                    rx_cnt <= '0;
                    rx_bit <= '0;
                    // falling edge starts a frame
                    if (!rx_line) begin
                        rx_state <= rx_s_start;
                    end
                end
                rx_s_start: begin
                    if (rx_cnt == half_last) begin
                        rx_cnt   <= '0;
                        // glitch check at start bit middle
                        rx_state <= rx_line ? rx_s_idle : rx_s_data;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                rx_s_data: begin
                    if (rx_cnt == bit_last) begin
                        rx_cnt <= '0;
                        rx_bit <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= rx_s_stop;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                rx_s_stop: begin
                    if (rx_cnt == bit_last) begin
                        rx_cnt   <= '0;
                        rx_state <= rx_s_idle;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: rx_state <= rx_s_idle;
            endcase
        end
    end

    // shift in at mid-bit, lsb arrives first
    always_ff @(posedge clk) begin
        if (rx_state == rx_s_data && rx_cnt == bit_last) begin
            rx_shift <= {rx_line, rx_shift[7:1]};
        end
        if (rx_done) begin
            rx_data <= rx_shift;
        end
    end

    // new byte wins over ack, overwrites an unread one
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_valid <= 1'b0;
        end else if (rx_done) begin
            rx_valid <= 1'b1;
        end else if (rx_ack) begin
            rx_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs #(
    parameter int cpu_clock_freq = 50_000_000,
    parameter int baud_rate      = 115_200
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         we,
    input  logic                         re,
    input  logic [4:0]                   addr,
    input  logic [mem_map_pkg::xlen-1:0] wdata,
    output logic [mem_map_pkg::xlen-1:0] rdata,
    input  logic                         retire,
    input  logic                         serial_in,
    output logic                         serial_out
);
    import mem_map_pkg::*;

    logic [7:0]      tx_data;
    logic            tx_valid;
    logic            tx_ready;
    logic [7:0]      rx_data;
    logic            rx_valid;
    logic            rx_ack;
    logic            cnt_clear;
    logic [xlen-1:0] cycle_cnt;
    logic [xlen-1:0] retire_cnt;

    // store to the tx register launches a byte
    assign tx_valid  = we && (addr == io_uart_tx);
    assign tx_data   = wdata[7:0];
    // reading the rx register consumes the byte
    assign rx_ack    = re && (addr == io_uart_rx);
    assign cnt_clear = we && (addr == io_cnt_clear);

    // performance counters
    always_ff @(posedge clk) begin
        if (rst || cnt_clear) begin
            cycle_cnt  <= '0;
            retire_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (retire) begin
                retire_cnt <= retire_cnt + 1'b1;
            end
        end
    end

    // registered read, same latency as the RAMs
    always_ff @(posedge clk) begin
        if (re) begin
            case (addr)
                io_uart_ctrl: rdata <= {{(xlen-2){1'b0}}, rx_valid, tx_ready};
                io_uart_rx:   rdata <= {{(xlen-8){1'b0}}, rx_data};
                io_cycles:    rdata <= cycle_cnt;
                io_retired:   rdata <= retire_cnt;
                default:      rdata <= '0;
            endcase
        end
    end

    uart_link #(
        .cpu_clock_freq(cpu_clock_freq),
        .baud_rate(baud_rate)
    ) uart_link_i (
        .clk(clk),
        .rst(rst),
        .tx_data(tx_data),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .rx_data(rx_data),
        .rx_valid(rx_valid),
        .rx_ack(rx_ack),
        .serial_in(serial_in),
        .serial_out(serial_out)
    );

endmodule

`default_nettype wire

// File: verilog/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
    parameter int cpu_clock_freq = 50_000_000,
    parameter int baud_rate      = 115_200
) (
    input  logic                         clk,
    input  logic                         rst,
    // fetch port of the core
    input  logic [mem_map_pkg::xlen-1:0] fetch_addr,
    input  logic                         fetch_en,
    output logic [mem_map_pkg::xlen-1:0] instr,
    // load/store port of the core
    input  logic [mem_map_pkg::xlen-1:0] data_addr,
    input  logic [mem_map_pkg::xlen-1:0] data_wdata,
    input  logic [3:0]                   data_we,
    input  logic                         data_re,
    output logic [mem_map_pkg::xlen-1:0] data_rdata,
    input  logic                         retire,
    input  logic                         serial_in,
    output logic                         serial_out
);
    import mem_map_pkg::*;

    // instruction source, one cycle behind fetch_addr
    typedef enum logic [1:0] {isel_bios, isel_imem, isel_zero} isel_t;

    region_t         fetch_region;
    region_t         data_region;
    isel_t           isel;
    rsel_t           rsel;
    logic [3:0]      imem_we;
    logic [3:0]      dmem_we;
    logic            io_we;
    logic            io_re;
    logic            dmem_en;
    logic [xlen-1:0] bios_instr;
    logic [xlen-1:0] bios_data;
    logic [xlen-1:0] imem_instr;
    logic [xlen-1:0] dmem_data;
    logic [xlen-1:0] io_data;

    assign fetch_region = region_t'(fetch_addr[xlen-1:xlen-4]);
    assign data_region  = region_t'(data_addr[xlen-1:xlen-4]);

    // held on stall along with the memory outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            isel <= isel_zero;
        end else if (fetch_en) begin
            case (fetch_region)
                reg_bios: isel <= isel_bios;
                // program memory lives at 0x1000_0000
                reg_dmem: isel <= isel_imem;
                default:  isel <= isel_zero;
            endcase
        end
    end

    always_comb begin
        case (isel)
            isel_bios: instr = bios_instr;
            isel_imem: instr = imem_instr;
            default:   instr = '0;
        endcase
    end

    // load read-back
    always_comb begin
        case (rsel)
            rsel_dmem: data_rdata = dmem_data;
            rsel_bios: data_rdata = bios_data;
            rsel_io:   data_rdata = io_data;
            default:   data_rdata = '0;
        endcase
    end

    bios_rom bios_rom_i (
        .clk(clk),
        .a_en(fetch_en),
        .a_addr(fetch_addr[bios_aw+1:2]),
        .a_data(bios_instr),
        .b_en(dmem_en),
        .b_addr(data_addr[bios_aw+1:2]),
        .b_data(bios_data)
    );

    imem_ram imem_ram_i (
        .clk(clk),
        .we(imem_we),
        .waddr(data_addr[imem_aw+1:2]),
        .wdata(data_wdata),
        .r_en(fetch_en),
        .raddr(fetch_addr[imem_aw+1:2]),
        .rdata(imem_instr)
    );

    dmem_ram dmem_ram_i (
        .clk(clk),
        .en(dmem_en),
        .we(dmem_we),
        .addr(data_addr[imem_aw+1:2]),
        .wdata(data_wdata),
        .rdata(dmem_data)
    );

    mem_decode mem_decode_i (
        .clk(clk),
        .rst(rst),
        .data_region(data_region),
        .fetch_region(fetch_region),
        .data_we(data_we),
        .data_re(data_re),
        .imem_we(imem_we),
        .dmem_we(dmem_we),
        .io_we(io_we),
        .io_re(io_re),
        .dmem_en(dmem_en),
        .rsel(rsel)
    );

    io_regs #(
        .cpu_clock_freq(cpu_clock_freq),
        .baud_rate(baud_rate)
    ) io_regs_i (
        .clk(clk),
        .rst(rst),
        .we(io_we),
        .re(io_re),
        .addr(data_addr[6:2]),
        .wdata(data_wdata),
        .rdata(io_data),
        .retire(retire),
        .serial_in(serial_in),
        .serial_out(serial_out)
    );

endmodule

`default_nettype wire

// File: verification/soc_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module soc_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic [3:0]           imem_we,
    input mem_map_pkg::region_t fetch_region,
    input logic                 serial_out,
    input logic                 tx_valid,
    input logic                 tx_ready
);
    import mem_map_pkg::*;

    // bumped by every failing property
    int unsigned fail_count = 0;

    // imem only writable while running from bios
    imem_boot_only: assert property (@(posedge clk) disable iff (rst)
        (|imem_we) |-> (fetch_region == reg_bios))
    else begin
        fail_count++;
        $error("imem written while fetch region is not bios");
    end

    // line idles high through reset
    line_high_in_reset: assert property (@(posedge clk) rst |-> serial_out)
    else begin
        fail_count++;
        $error("serial_out low during reset");
    end

    // accepted byte takes the transmitter busy
    tx_busy_after_accept: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && tx_ready) |=> !tx_ready)
    else begin
        fail_count++;
        $error("tx ready still high after an accepted transmit write");
    end

endmodule

bind soc_top soc_asserts soc_asserts_i (
    .clk(clk),
    .rst(rst),
    .imem_we(imem_we),
    .fetch_region(fetch_region),
    .serial_out(serial_out),
    .tx_valid(io_regs_i.tx_valid),
    .tx_ready(io_regs_i.tx_ready)
);

`default_nettype wire

// File: verification/soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_tb;
    import mem_map_pkg::*;

    // 10 clocks per uart bit
    localparam int clk_freq = 25_000_000;
    localparam int baud     = 2_500_000;
    // uart loopback needs about 300 cycles of this
    localparam int max_cycles = 4000;

    logic            clk;
    logic            rst;
    logic [xlen-1:0] fetch_addr;
    logic            fetch_en;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] data_addr;
    logic [xlen-1:0] data_wdata;
    logic [3:0]      data_we;
    logic            data_re;
    logic [xlen-1:0] data_rdata;
    logic            retire;
    // serial_out looped straight back into serial_in
    wire             serial_line;

    int unsigned cycles = 0;
    int unsigned checks;
    int unsigned errors;
    int unsigned tests;
    int unsigned total_fail;

    soc_top #(
        .cpu_clock_freq(clk_freq),
        .baud_rate(baud)
    ) soc_top_i (
        .clk(clk),
        .rst(rst),
        .fetch_addr(fetch_addr),
        .fetch_en(fetch_en),
        .instr(instr),
        .data_addr(data_addr),
        .data_wdata(data_wdata),
        .data_we(data_we),
        .data_re(data_re),
        .data_rdata(data_rdata),
        .retire(retire),
        .serial_in(serial_line),
        .serial_out(serial_line)
    );

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // region nibble above the byte address
    function automatic logic [xlen-1:0] region_addr(region_t r, int unsigned word);
        return {r, 28'(word * 4)};
    endfunction

    function automatic logic [xlen-1:0] io_addr(logic [4:0] off);
        return {reg_io, 21'h0, off, 2'b00};
    endfunction

    // bios image rule
    function automatic logic [xlen-1:0] bios_word(int unsigned i);
        return 32'hB105_0000 + i;
    endfunction

    task automatic compare_word(input string what, input logic [xlen-1:0] got,
                                input logic [xlen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // all bus tasks start and end on a falling edge
    task automatic store(input logic [xlen-1:0] addr, input logic [xlen-1:0] wdata,
                         input logic [3:0] be);
        data_addr  = addr;
        data_wdata = wdata;
        data_we    = be;
        @(negedge clk);
        data_we = 4'b0000;
    endtask

    task automatic load(input logic [xlen-1:0] addr, output logic [xlen-1:0] rdata);
        data_addr = addr;
        data_re   = 1'b1;
        @(negedge clk);
        data_re = 1'b0;
        rdata   = data_rdata;
    endtask

    task automatic fetch(input logic [xlen-1:0] addr, output logic [xlen-1:0] word);
        fetch_addr = addr;
        fetch_en   = 1'b1;
        @(negedge clk);
        word = instr;
    endtask

    task automatic dmem_byte_merge;
        logic [xlen-1:0] model [8];
        logic [xlen-1:0] wdata;
        logic [xlen-1:0] got;
        logic [3:0]      be;
        int unsigned     err0;
        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            model[i] = $urandom();
            store(region_addr(reg_dmem, i), model[i], 4'b1111);
        end
        // partial stores merge into the known words
        for (int i = 0; i < 8; i++) begin
            wdata = $urandom();
            be    = 4'($urandom());
            store(region_addr(reg_dmem, i), wdata, be);
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    model[i][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        for (int i = 0; i < 8; i++) begin
            load(region_addr(reg_dmem, i), got);
            compare_word($sformatf("dmem word %0d", i), got, model[i]);
        end
        $display("dmem test done, %0d errors", errors - err0);
    endtask

    task automatic bios_read_ports;
        logic [xlen-1:0] got;
        int unsigned     idx;
        int unsigned     err0;
        err0 = errors;
        idx  = 0;
        for (int n = 0; n < 6; n++) begin
            idx = $urandom_range(15, 0);
            fetch(region_addr(reg_bios, idx), got);
            compare_word($sformatf("bios fetch %0d", idx), got, bios_word(idx));
            load(region_addr(reg_bios, idx), got);
            compare_word($sformatf("bios load %0d", idx), got, bios_word(idx));
        end
        // new address must not reach instr during the stall
        fetch_en   = 1'b0;
        fetch_addr = region_addr(reg_bios, (idx + 1) % 16);
        repeat (3) begin
            @(negedge clk);
            compare_word("instr under fetch stall", instr, bios_word(idx));
        end
        fetch_en = 1'b1;
        $display("bios test done, %0d errors", errors - err0);
    endtask

    task automatic imem_boot_write;
        logic [xlen-1:0] word_a;
        logic [xlen-1:0] word_b;
        logic [xlen-1:0] got;
        int unsigned     err0;
        err0   = errors;
        word_a = $urandom();
        word_b = $urandom();
        // fetching from bios makes imem writable
        fetch(region_addr(reg_bios, 0), got);
        store(region_addr(reg_imem, 'h40), word_a, 4'b1111);
        store(region_addr(reg_both, 'h41), word_b, 4'b1111);
        fetch(region_addr(reg_dmem, 'h40), got);
        compare_word("imem fetch of imem store", got, word_a);
        fetch(region_addr(reg_dmem, 'h41), got);
        compare_word("imem fetch of both store", got, word_b);
        load(region_addr(reg_dmem, 'h41), got);
        compare_word("dmem load of both store", got, word_b);
        load(region_addr(reg_both, 'h41), got);
        compare_word("both-region load", got, word_b);
        // store while fetching from dmem is dropped
        store(region_addr(reg_imem, 'h40), ~word_a, 4'b1111);
        fetch(region_addr(reg_dmem, 'h40), got);
        compare_word("imem after store outside boot", got, word_a);
        fetch(region_addr(reg_bios, 0), got);
        $display("imem test done, %0d errors", errors - err0);
    endtask

    task automatic uart_loopback;
        logic [7:0]      tx_byte;
        logic [xlen-1:0] got;
        int unsigned     err0;
        err0    = errors;
        tx_byte = 8'($urandom());
        // tx ready and nothing received after reset
        load(io_addr(io_uart_ctrl), got);
        compare_word("uart ctrl when idle", got, 32'h1);
        compare_word("serial line idle", {31'h0, serial_line}, 32'h1);
        while (got[0] !== 1'b1) begin
            load(io_addr(io_uart_ctrl), got);
        end
        store(io_addr(io_uart_tx), {24'h0, tx_byte}, 4'b1111);
        load(io_addr(io_uart_ctrl), got);
        compare_word("tx ready after send", {31'h0, got[0]}, 32'h0);
        // frame comes back through the loop
        while (got[1] !== 1'b1) begin
            load(io_addr(io_uart_ctrl), got);
        end
        load(io_addr(io_uart_rx), got);
        compare_word("uart loopback byte", got, {24'h0, tx_byte});
        load(io_addr(io_uart_ctrl), got);
        compare_word("rx valid after read", {31'h0, got[1]}, 32'h0);
        $display("uart test done, %0d errors", errors - err0);
    endtask

    task automatic counter_readback;
        logic [xlen-1:0] got;
        logic [xlen-1:0] c1;
        logic [xlen-1:0] c2;
        int unsigned     n_retire;
        int unsigned     gap;
        int unsigned     err0;
        err0     = errors;
        n_retire = $urandom_range(20, 1);
        store(io_addr(io_cnt_clear), 32'h0, 4'b1111);
        for (int i = 0; i < n_retire; i++) begin
            retire = 1'b1;
            @(negedge clk);
            retire = 1'b0;
            repeat ($urandom_range(2, 0))
                @(negedge clk);
        end
        load(io_addr(io_retired), got);
        compare_word("retired count", got, n_retire);
        // two loads issued gap cycles apart
        gap = $urandom_range(30, 3);
        load(io_addr(io_cycles), c1);
        repeat (gap - 1) @(negedge clk);
        load(io_addr(io_cycles), c2);
        compare_word("cycle count delta", c2 - c1, gap);
        $display("counter test done, %0d errors", errors - err0);
    endtask

    initial begin
        void'($urandom(32'he8b89d57));
        clk        = 1'b0;
        rst        = 1'b1;
        fetch_addr = region_addr(reg_bios, 0);
        fetch_en   = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        data_we    = 4'b0000;
        data_re    = 1'b0;
        retire     = 1'b0;
        checks     = 0;
        errors     = 0;
        tests      = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        dmem_byte_merge();
        tests++;
        bios_read_ports();
        tests++;
        imem_boot_write();
        tests++;
        uart_loopback();
        tests++;
        counter_readback();
        tests++;
        total_fail = errors + soc_top_i.soc_asserts_i.fail_count;
        $display("tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 tests, checks, errors, soc_top_i.soc_asserts_i.fail_count);
        if (total_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/bios.hex
B1050000
B1050001
B1050002
B1050003
B1050004
B1050005
B1050006
B1050007
B1050008
B1050009
B105000A
B105000B
B105000C
B105000D
B105000E
B105000F

// File: verilog.f
verilog/mem_map_pkg.sv
verilog/bios_rom.sv
verilog/imem_ram.sv
verilog/dmem_ram.sv
verilog/mem_decode.sv
verilog/uart_link.sv
verilog/io_regs.sv
verilog/soc_top.sv
verification/soc_asserts.sv
verification/soc_tb.sv

// File: Bender.yml
package:
  name: soc_mem_io

sources:
  - verilog/mem_map_pkg.sv
  - verilog/bios_rom.sv
  - verilog/imem_ram.sv
  - verilog/dmem_ram.sv
  - verilog/mem_decode.sv
  - verilog/uart_link.sv
  - verilog/io_regs.sv
  - verilog/soc_top.sv
  - target: test
    files:
      - verification/soc_asserts.sv
      - verification/soc_tb.sv
